//--- include/mem_stage_consts.svh
`ifndef MEM_STAGE_CONSTS_SVH
`define MEM_STAGE_CONSTS_SVH

// data path width in bits.
`define MEM_DATA_W 32

// byte address width on both bus address channels.
`define MEM_ADDR_W 32

// data memory size in 32-bit words, a power of two.
`define MEM_DEPTH_WORDS 256

// byte lanes per data word.
`define MEM_STRB_W (`MEM_DATA_W / 8)

`endif

//--- logic/mem_stage_pkg.sv
`include "mem_stage_consts.svh"

package mem_stage_pkg;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_e;

  typedef enum logic [1:0] {
    WIDTH_BYTE = 2'd0,
    WIDTH_HALF = 2'd1,
    WIDTH_WORD = 2'd2
  } mem_width_e;

  // source of the register write value.
  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_LOAD = 2'd1,
    WB_LINK = 2'd2, // pc + 4.
    WB_SRC2 = 2'd3
  } wb_sel_e;

  typedef enum logic {
    CSR_ALU = 1'b0,
    CSR_PC  = 1'b1
  } csr_sel_e;

  // one instruction handed over from execute.
  typedef struct packed {
    mem_op_e                op;
    mem_width_e             width;
    logic                   load_signed;
    logic [`MEM_ADDR_W-1:0] addr;        // alu result.
    logic [`MEM_DATA_W-1:0] src2;        // store data.
    wb_sel_e                wb_sel;
    csr_sel_e               csr_sel;
    logic [`MEM_ADDR_W-1:0] pc;
    logic [`MEM_ADDR_W-1:0] pc_next;
    logic [31:0]            instruction;
    logic [4:0]             rd;
    logic [1:0]             csr_rd;
    logic                   reg_write_en;
    logic                   csreg_write_en;
    logic                   ecall;
  } lsu_req_t;

  // result toward writeback.
  typedef struct packed {
    logic [`MEM_DATA_W-1:0] wd;
    logic [`MEM_DATA_W-1:0] csr_wd;
    logic [4:0]             rd;
    logic [1:0]             csr_rd;
    logic [`MEM_ADDR_W-1:0] pc;
    logic [`MEM_ADDR_W-1:0] pc_next;
    logic [31:0]            instruction;
    logic                   reg_write_en;
    logic                   csreg_write_en;
    logic                   ecall;
  } lsu_rsp_t;

  typedef struct packed {
    logic [`MEM_ADDR_W-1:0] addr;
  } axi_addr_t;

  typedef struct packed {
    logic [`MEM_DATA_W-1:0] data;
    logic [`MEM_STRB_W-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    logic [`MEM_DATA_W-1:0] data;
    logic [1:0]             resp;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

endpackage

//--- logic/writeback_select.sv
`timescale 1ns/1ns
`include "mem_stage_consts.svh"

module writeback_select (
  input  mem_stage_pkg::lsu_req_t req,
  input  logic [`MEM_DATA_W-1:0]  read_word,
  output logic [`MEM_DATA_W-1:0]  wd,
  output logic [`MEM_DATA_W-1:0]  csr_wd
);

  logic [`MEM_DATA_W-1:0] shifted;
  logic [`MEM_DATA_W-1:0] load_val;

  assign shifted = read_word >> {req.addr[1:0], 3'b000}; // addressed lane to bit 0.

  always_comb begin
    case (req.width)
      mem_stage_pkg::WIDTH_BYTE: begin
        if (req.load_signed) load_val = {{(`MEM_DATA_W-8){shifted[7]}}, shifted[7:0]};
        else                 load_val = {{(`MEM_DATA_W-8){1'b0}}, shifted[7:0]};
      end
      mem_stage_pkg::WIDTH_HALF: begin
        if (req.load_signed) load_val = {{(`MEM_DATA_W-16){shifted[15]}}, shifted[15:0]};
        else                 load_val = {{(`MEM_DATA_W-16){1'b0}}, shifted[15:0]};
      end
      default: load_val = shifted;
    endcase
  end

  always_comb begin
    case (req.wb_sel)
      mem_stage_pkg::WB_LOAD: wd = load_val;
      mem_stage_pkg::WB_LINK: wd = req.pc + 32'd4; // return address for jal/jalr.
      mem_stage_pkg::WB_SRC2: wd = req.src2;
      default:                wd = req.addr;
    endcase
  end

  always_comb begin
    case (req.csr_sel)
      mem_stage_pkg::CSR_PC: csr_wd = req.pc;  // mepc on ecall.
      default:               csr_wd = req.addr;
    endcase
  end

endmodule

//--- logic/lsu.sv
`timescale 1ns/1ns
`include "mem_stage_consts.svh"

module lsu (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  mem_stage_pkg::lsu_req_t in_req,
  output logic                    busy,
  output logic                    arvalid,
  input  logic                    arready,
  output mem_stage_pkg::axi_addr_t ar,
  input  logic                    rvalid,
  output logic                    rready,
  input  mem_stage_pkg::axi_r_t   r,
  output logic                    awvalid,
  input  logic                    awready,
  output mem_stage_pkg::axi_addr_t aw,
  output logic                    wvalid,
  input  logic                    wready,
  output mem_stage_pkg::axi_w_t   w,
  input  logic                    bvalid,
  output logic                    bready,
  input  mem_stage_pkg::axi_b_t   b,
  output logic                    out_valid,
  output mem_stage_pkg::lsu_rsp_t out_rsp
);

  typedef enum logic [2:0] {
    IDLE,
    READ_ADDR,
    READ_DATA,
    WRITE_ADDR,
    WRITE_RESP,
    DONE
  } state_e;

  state_e                  state;
  state_e                  state_next;
  logic                    accept;
  mem_stage_pkg::lsu_req_t req_q;
  mem_stage_pkg::axi_w_t   w_next;
  mem_stage_pkg::axi_w_t   w_q;
  logic [`MEM_DATA_W-1:0]  rdata_q;
  logic [`MEM_DATA_W-1:0]  wd;
  logic [`MEM_DATA_W-1:0]  csr_wd;

  assign busy   = (state != IDLE);
  assign accept = in_valid && !busy;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (accept) begin
          case (in_req.op)
            mem_stage_pkg::MEM_LOAD:  state_next = READ_ADDR;
            mem_stage_pkg::MEM_STORE: state_next = WRITE_ADDR;
            default:                  state_next = DONE;
          endcase
        end
      end
      READ_ADDR:  if (arvalid && arready) state_next = READ_DATA;
      READ_DATA:  if (rvalid && rready) state_next = DONE;
      // address and data go across on the same edge.
      WRITE_ADDR: if (awvalid && awready && wready) state_next = WRITE_RESP;
      WRITE_RESP: if (bvalid && bready) state_next = DONE;
      DONE:       state_next = IDLE;
      default:    state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // lane placement for stores, replicated so the strobe picks the lane.
  always_comb begin
    w_next = '0;
    case (in_req.width)
      mem_stage_pkg::WIDTH_BYTE: begin
        w_next.data = {4{in_req.src2[7:0]}};
        w_next.strb = 4'b0001 << in_req.addr[1:0];
      end
      mem_stage_pkg::WIDTH_HALF: begin
        w_next.data = {2{in_req.src2[15:0]}};
        w_next.strb = 4'b0011 << in_req.addr[1:0];
      end
      default: begin
        w_next.data = in_req.src2;
        w_next.strb = '1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= in_req;
      w_q   <= w_next;
    end
    if (rvalid && rready) rdata_q <= r.data;
  end

  // bus channels, all decoded from the registered state.
  assign arvalid = (state == READ_ADDR);
  assign ar.addr = req_q.addr;
  assign rready  = (state == READ_DATA);
  assign awvalid = (state == WRITE_ADDR);
  assign wvalid  = (state == WRITE_ADDR);
  assign aw.addr = req_q.addr;
  assign w       = w_q;
  assign bready  = (state == WRITE_RESP);

  writeback_select writeback_select_inst (
    .req       (req_q),
    .read_word (rdata_q),
    .wd        (wd),
    .csr_wd    (csr_wd)
  );

  assign out_valid = (state == DONE);

  always_comb begin
    out_rsp.wd             = wd;
    out_rsp.csr_wd         = csr_wd;
    out_rsp.rd             = req_q.rd;
    out_rsp.csr_rd         = req_q.csr_rd;
    out_rsp.pc             = req_q.pc;
    out_rsp.pc_next        = req_q.pc_next;
    out_rsp.instruction    = req_q.instruction;
    out_rsp.reg_write_en   = req_q.reg_write_en;
    out_rsp.csreg_write_en = req_q.csreg_write_en;
    out_rsp.ecall          = req_q.ecall;
  end

endmodule

//--- logic/data_sram_axi.sv
`timescale 1ns/1ns
`include "mem_stage_consts.svh"

module data_sram_axi (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     arvalid,
  output logic                     arready,
  input  mem_stage_pkg::axi_addr_t ar,
  output logic                     rvalid,
  input  logic                     rready,
  output mem_stage_pkg::axi_r_t    r,
  input  logic                     awvalid,
  output logic                     awready,
  input  mem_stage_pkg::axi_addr_t aw,
  input  logic                     wvalid,
  output logic                     wready,
  input  mem_stage_pkg::axi_w_t    w,
  output logic                     bvalid,
  input  logic                     bready,
  output mem_stage_pkg::axi_b_t    b
);

  localparam int IDX_W = $clog2(`MEM_DEPTH_WORDS);

  logic [`MEM_DATA_W-1:0] mem [0:`MEM_DEPTH_WORDS-1];
  logic [`MEM_DATA_W-1:0] rdata_q;
  logic [IDX_W-1:0]       rd_idx;
  logic [IDX_W-1:0]       wr_idx;
  logic                   rd_fire;
  logic                   wr_fire;

  // word index, upper address bits drop off so it wraps.
  assign rd_idx = ar.addr[IDX_W+1:2];
  assign wr_idx = aw.addr[IDX_W+1:2];

  assign arready = !rvalid; // one read in flight.
  assign rd_fire = arvalid && arready;

  // address and data taken together, only with both present.
  assign awready = awvalid && wvalid && !bvalid;
  assign wready  = awready;
  assign wr_fire = awvalid && awready && wvalid && wready;

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      if (rd_fire) rvalid <= 1'b1;
      else if (rvalid && rready) rvalid <= 1'b0;
      if (wr_fire) bvalid <= 1'b1;
      else if (bvalid && bready) bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) rdata_q <= mem[rd_idx];
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int i = 0; i < `MEM_STRB_W; i++) begin
        if (w.strb[i]) mem[wr_idx][i*8 +: 8] <= w.data[i*8 +: 8];
      end
    end
  end

  assign r.data = rdata_q;
  assign r.resp = 2'b00; // always OKAY.
  assign b.resp = 2'b00;

endmodule

//--- logic/mem_stage_top.sv
`timescale 1ns/1ns

module mem_stage_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  mem_stage_pkg::lsu_req_t in_req,
  output logic                    busy,
  output logic                    out_valid,
  output mem_stage_pkg::lsu_rsp_t out_rsp
);

  logic                     arvalid;
  logic                     arready;
  mem_stage_pkg::axi_addr_t ar;
  logic                     rvalid;
  logic                     rready;
  mem_stage_pkg::axi_r_t    r;
  logic                     awvalid;
  logic                     awready;
  mem_stage_pkg::axi_addr_t aw;
  logic                     wvalid;
  logic                     wready;
  mem_stage_pkg::axi_w_t    w;
  logic                     bvalid;
  logic                     bready;
  mem_stage_pkg::axi_b_t    b;

  lsu lsu_inst (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .busy      (busy),
    .arvalid   (arvalid),
    .arready   (arready),
    .ar        (ar),
    .rvalid    (rvalid),
    .rready    (rready),
    .r         (r),
    .awvalid   (awvalid),
    .awready   (awready),
    .aw        (aw),
    .wvalid    (wvalid),
    .wready    (wready),
    .w         (w),
    .bvalid    (bvalid),
    .bready    (bready),
    .b         (b),
    .out_valid (out_valid),
    .out_rsp   (out_rsp)
  );

  data_sram_axi data_sram_axi_inst (
    .clk     (clk),
    .rst     (rst),
    .arvalid (arvalid),
    .arready (arready),
    .ar      (ar),
    .rvalid  (rvalid),
    .rready  (rready),
    .r       (r),
    .awvalid (awvalid),
    .awready (awready),
    .aw      (aw),
    .wvalid  (wvalid),
    .wready  (wready),
    .w       (w),
    .bvalid  (bvalid),
    .bready  (bready),
    .b       (b)
  );

endmodule

//--- verif/mem_stage_props.sv
`timescale 1ns/1ns

module mem_stage_props (
  input logic                     clk,
  input logic                     rst,
  input logic                     in_valid,
  input logic                     busy,
  input logic                     arvalid,
  input logic                     arready,
  input mem_stage_pkg::axi_addr_t ar,
  input logic                     awvalid,
  input logic                     awready,
  input mem_stage_pkg::axi_addr_t aw,
  input logic                     wvalid,
  input logic                     rvalid,
  input logic                     rready,
  input logic                     bvalid,
  input logic                     bready,
  input logic                     out_valid
);

  ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid && !arready |=> arvalid && $stable(ar))
    else $error("arvalid or read address changed before the transfer");

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid && !awready |=> awvalid && wvalid && $stable(aw))
    else $error("awvalid, wvalid or write address changed before the transfer");

  out_pulse: assert property (@(posedge clk) disable iff (rst)
    out_valid |=> !out_valid)
    else $error("out_valid held longer than one cycle");

  no_req_when_busy: assert property (@(posedge clk) disable iff (rst)
    in_valid |-> !busy)
    else $error("in_valid raised while the stage was busy");

  // a ready wait opens with the address transfer and lasts until the response arrives.
  rready_state: assert property (@(posedge clk) disable iff (rst)
    rready |-> $past(arvalid && arready) || $past(rready && !rvalid))
    else $error("rready high outside the read data wait");

  bready_state: assert property (@(posedge clk) disable iff (rst)
    bready |-> $past(awvalid && awready) || $past(bready && !bvalid))
    else $error("bready high outside the write response wait");

endmodule

bind lsu mem_stage_props mem_stage_props_inst (
  .clk       (clk),
  .rst       (rst),
  .in_valid  (in_valid),
  .busy      (busy),
  .arvalid   (arvalid),
  .arready   (arready),
  .ar        (ar),
  .awvalid   (awvalid),
  .awready   (awready),
  .aw        (aw),
  .wvalid    (wvalid),
  .rvalid    (rvalid),
  .rready    (rready),
  .bvalid    (bvalid),
  .bready    (bready),
  .out_valid (out_valid)
);

//--- verif/mem_stage_tb.sv
`timescale 1ns/1ns
`include "mem_stage_consts.svh"

module mem_stage_tb;

  localparam int PERIOD       = 4;
  localparam int N_DIRECTED   = 35;
  localparam int N_FILL       = `MEM_DEPTH_WORDS;
  localparam int N_RANDOM     = 200;
  localparam int N_REQS       = N_DIRECTED + N_FILL + N_RANDOM;
  localparam int SHADOW_BYTES = 4 * `MEM_DEPTH_WORDS;

  logic                    clk;
  logic                    rst;
  logic                    in_valid;
  mem_stage_pkg::lsu_req_t in_req;
  logic                    busy;
  logic                    out_valid;
  mem_stage_pkg::lsu_rsp_t out_rsp;

  logic [7:0]              shadow [0:SHADOW_BYTES-1];
  mem_stage_pkg::lsu_rsp_t exp_q [$];
  string                   name_q [$];
  logic [31:0]             rng_state = 32'hf55a;
  time                     drive_time;
  time                     rsp_time;
  int                      n_issued = 0;
  int                      n_checked = 0;

  mem_stage_top mem_stage_top_inst (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .busy      (busy),
    .out_valid (out_valid),
    .out_rsp   (out_rsp)
  );

  always #(PERIOD / 2) clk = ~clk;

  // lcg step with the upper bits folded onto the quickly cycling low bits.
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state ^ (rng_state >> 15);
  endfunction

  function automatic int byte_idx(input logic [31:0] a);
    return int'(a % 32'(SHADOW_BYTES));
  endfunction

  // expected writeback result with loads read from the shadow bytes.
  function automatic mem_stage_pkg::lsu_rsp_t ref_rsp(input mem_stage_pkg::lsu_req_t req);
    mem_stage_pkg::lsu_rsp_t rsp;
    logic [31:0]             ld;
    logic [7:0]              b0;
    logic [15:0]             h0;
    int                      i;
    i  = byte_idx(req.addr);
    b0 = shadow[i];
    h0 = {shadow[(i + 1) % SHADOW_BYTES], shadow[i]};
    case (req.width)
      mem_stage_pkg::WIDTH_BYTE: ld = req.load_signed ? {{24{b0[7]}}, b0} : {24'h0, b0};
      mem_stage_pkg::WIDTH_HALF: ld = req.load_signed ? {{16{h0[15]}}, h0} : {16'h0, h0};
      default: ld = {shadow[i + 3], shadow[i + 2], shadow[i + 1], shadow[i]};
    endcase
    case (req.wb_sel)
      mem_stage_pkg::WB_LOAD: rsp.wd = ld;
      mem_stage_pkg::WB_LINK: rsp.wd = req.pc + 32'd4;
      mem_stage_pkg::WB_SRC2: rsp.wd = req.src2;
      default:                rsp.wd = req.addr;
    endcase
    rsp.csr_wd         = (req.csr_sel == mem_stage_pkg::CSR_PC) ? req.pc : req.addr;
    rsp.rd             = req.rd;
    rsp.csr_rd         = req.csr_rd;
    rsp.pc             = req.pc;
    rsp.pc_next        = req.pc_next;
    rsp.instruction    = req.instruction;
    rsp.reg_write_en   = req.reg_write_en;
    rsp.csreg_write_en = req.csreg_write_en;
    rsp.ecall          = req.ecall;
    return rsp;
  endfunction

  task automatic apply_store(input mem_stage_pkg::lsu_req_t req);
    int i;
    i = byte_idx(req.addr);
    shadow[i] = req.src2[7:0];
    if (req.width != mem_stage_pkg::WIDTH_BYTE) shadow[i + 1] = req.src2[15:8];
    if (req.width == mem_stage_pkg::WIDTH_WORD) begin
      shadow[i + 2] = req.src2[23:16];
      shadow[i + 3] = req.src2[31:24];
    end
  endtask

  task automatic compare_field(input string name, input string field, input logic [31:0] e,
                               input logic [31:0] a);
    if (a !== e) begin
      $display("ERROR %s: %s expected %h actual %h", name, field, e, a);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic check_rsp(input string name, input mem_stage_pkg::lsu_rsp_t exp,
                           input mem_stage_pkg::lsu_rsp_t act);
    compare_field(name, "wd", exp.wd, act.wd);
    compare_field(name, "csr_wd", exp.csr_wd, act.csr_wd);
    compare_field(name, "rd", 32'(exp.rd), 32'(act.rd));
    compare_field(name, "csr_rd", 32'(exp.csr_rd), 32'(act.csr_rd));
    compare_field(name, "pc", exp.pc, act.pc);
    compare_field(name, "pc_next", exp.pc_next, act.pc_next);
    compare_field(name, "instruction", exp.instruction, act.instruction);
    compare_field(name, "enables/ecall",
                  32'({exp.reg_write_en, exp.csreg_write_en, exp.ecall}),
                  32'({act.reg_write_en, act.csreg_write_en, act.ecall}));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s: expected %b actual %b", name, exp, act);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("ERROR %s: expected %0d cycles actual %0d cycles", name, exp, act);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic check_idle(input string name);
    check_bit({name, " busy"}, 1'b0, busy);
    check_bit({name, " out_valid"}, 1'b0, out_valid);
  endtask

  function automatic mem_stage_pkg::lsu_req_t build_req(
    input mem_stage_pkg::mem_op_e    op,
    input mem_stage_pkg::mem_width_e width,
    input logic                      load_signed,
    input logic [31:0]               addr,
    input logic [31:0]               src2,
    input mem_stage_pkg::wb_sel_e    wb_sel,
    input mem_stage_pkg::csr_sel_e   csr_sel
  );
    mem_stage_pkg::lsu_req_t req;
    logic [31:0]             r;
    req.op          = op;
    req.width       = width;
    req.load_signed = load_signed;
    req.addr        = addr;
    req.src2        = src2;
    req.wb_sel      = wb_sel;
    req.csr_sel     = csr_sel;
    r               = next_rand();
    req.pc          = {r[31:2], 2'b00};
    req.pc_next     = req.pc + 32'd4;
    req.instruction = next_rand();
    r               = next_rand();
    req.rd             = r[4:0];
    req.csr_rd         = r[6:5];
    req.reg_write_en   = r[7];
    req.csreg_write_en = r[8];
    req.ecall          = r[9];
    return req;
  endfunction

  // present one request and wait until the stage is idle again.
  task automatic issue(input mem_stage_pkg::lsu_req_t req, input string name);
    while (busy) begin
      @(posedge clk);
      #1;
    end
    check_idle(name);
    exp_q.push_back(ref_rsp(req));
    name_q.push_back(name);
    if (req.op == mem_stage_pkg::MEM_STORE) apply_store(req);
    in_req     = req;
    in_valid   = 1'b1;
    drive_time = $time - 1;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    n_issued++;
    while (busy) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_none_test();
    mem_stage_pkg::wb_sel_e  wb_list [4];
    mem_stage_pkg::csr_sel_e csr_list [4];
    wb_list  = '{mem_stage_pkg::WB_ALU, mem_stage_pkg::WB_LINK,
                 mem_stage_pkg::WB_SRC2, mem_stage_pkg::WB_ALU};
    csr_list = '{mem_stage_pkg::CSR_ALU, mem_stage_pkg::CSR_PC,
                 mem_stage_pkg::CSR_ALU, mem_stage_pkg::CSR_PC};
    for (int k = 0; k < 4; k++) begin
      issue(build_req(mem_stage_pkg::MEM_NONE, mem_stage_pkg::WIDTH_WORD, 1'b0, next_rand(),
                      next_rand(), wb_list[k], csr_list[k]), "none passthrough");
      check_latency("none latency", 2, int'((rsp_time - drive_time) / PERIOD));
    end
  endtask

  task automatic run_lane_test(input logic [31:0] a);
    for (int off = 0; off < 4; off++) begin
      issue(build_req(mem_stage_pkg::MEM_STORE, mem_stage_pkg::WIDTH_BYTE, 1'b0,
                      a + 32'(off), next_rand(), mem_stage_pkg::WB_ALU,
                      mem_stage_pkg::CSR_ALU), "byte store");
      issue(build_req(mem_stage_pkg::MEM_LOAD, mem_stage_pkg::WIDTH_WORD, 1'b0, a, 32'h0,
                      mem_stage_pkg::WB_LOAD, mem_stage_pkg::CSR_ALU), "load after byte store");
    end
    for (int off = 0; off < 4; off += 2) begin
      issue(build_req(mem_stage_pkg::MEM_STORE, mem_stage_pkg::WIDTH_HALF, 1'b0,
                      a + 32'(off), next_rand(), mem_stage_pkg::WB_ALU,
                      mem_stage_pkg::CSR_ALU), "half store");
      issue(build_req(mem_stage_pkg::MEM_LOAD, mem_stage_pkg::WIDTH_WORD, 1'b0, a, 32'h0,
                      mem_stage_pkg::WB_LOAD, mem_stage_pkg::CSR_ALU), "load after half store");
    end
  endtask

  task automatic run_extend_test(input logic [31:0] a);
    // two positive and two negative bytes, one half of each sign.
    issue(build_req(mem_stage_pkg::MEM_STORE, mem_stage_pkg::WIDTH_WORD, 1'b0, a,
                    32'hf08c7e31, mem_stage_pkg::WB_ALU, mem_stage_pkg::CSR_ALU), "extend setup");
    for (int s = 0; s < 2; s++) begin
      for (int off = 0; off < 4; off++) begin
        issue(build_req(mem_stage_pkg::MEM_LOAD, mem_stage_pkg::WIDTH_BYTE, s[0],
                        a + 32'(off), 32'h0, mem_stage_pkg::WB_LOAD,
                        mem_stage_pkg::CSR_ALU), "byte load extend");
      end
      for (int off = 0; off < 4; off += 2) begin
        issue(build_req(mem_stage_pkg::MEM_LOAD, mem_stage_pkg::WIDTH_HALF, s[0],
                        a + 32'(off), 32'h0, mem_stage_pkg::WB_LOAD,
                        mem_stage_pkg::CSR_ALU), "half load extend");
      end
    end
  endtask

  task automatic run_select_test(input logic [31:0] a);
    mem_stage_pkg::mem_op_e op;
    for (int k = 0; k < 4; k++) begin
      op = (k < 2) ? mem_stage_pkg::MEM_LOAD : mem_stage_pkg::MEM_STORE;
      issue(build_req(op, mem_stage_pkg::WIDTH_WORD, 1'b0, a, next_rand(),
                      k[0] ? mem_stage_pkg::WB_SRC2 : mem_stage_pkg::WB_LINK,
                      mem_stage_pkg::CSR_PC), "link/src2/pc select");
    end
  endtask

  task automatic run_random_test(input int count);
    logic [31:0]                r;
    logic [31:0]                off;
    logic [31:0]                addr;
    mem_stage_pkg::mem_op_e     op;
    mem_stage_pkg::mem_width_e  width;
    mem_stage_pkg::wb_sel_e     wb_sel;
    for (int n = 0; n < count; n++) begin
      r      = next_rand() % 32'd3;
      op     = mem_stage_pkg::mem_op_e'(r[1:0]);
      r      = next_rand() % 32'd3;
      width  = mem_stage_pkg::mem_width_e'(r[1:0]);
      r      = next_rand();
      wb_sel = mem_stage_pkg::wb_sel_e'(r[1:0]);
      if (op != mem_stage_pkg::MEM_LOAD && wb_sel == mem_stage_pkg::WB_LOAD)
        wb_sel = mem_stage_pkg::WB_ALU; // no fresh read word to select.
      case (width)
        mem_stage_pkg::WIDTH_BYTE: off = {30'h0, r[3:2]};
        mem_stage_pkg::WIDTH_HALF: off = {30'h0, r[3], 1'b0};
        default:                   off = 32'h0;
      endcase
      addr = (next_rand() % 32'(`MEM_DEPTH_WORDS)) << 2;
      issue(build_req(op, width, r[4], addr | off, next_rand(), wb_sel,
                      mem_stage_pkg::csr_sel_e'(r[5])), "random");
    end
  endtask

  // compares every result pulse against the oldest expectation.
  always @(posedge clk) begin : compare_proc
    mem_stage_pkg::lsu_rsp_t exp;
    string                   nm;
    if (!rst && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("out_valid pulsed with no request outstanding");
        $display("Something failed");
        $fatal(1);
      end else begin
        exp = exp_q.pop_front();
        nm  = name_q.pop_front();
        check_rsp(nm, exp, out_rsp);
        rsp_time = $time;
        n_checked++;
      end
    end
  end

  initial begin
    #(N_REQS * 40 * PERIOD + 20 * PERIOD);
    $display("watchdog expired before all requests completed");
    $display("Something failed");
    $fatal(1);
  end

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    in_valid = 1'b0;
    in_req   = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (3) begin
      check_idle("after reset");
      @(posedge clk);
      #1;
    end
    run_none_test();
    for (int i = 0; i < N_FILL; i++) begin
      issue(build_req(mem_stage_pkg::MEM_STORE, mem_stage_pkg::WIDTH_WORD, 1'b0, i * 4,
                      (i * 32'h9e3779b1) ^ 32'h5a5a0f0f, mem_stage_pkg::WB_ALU,
                      mem_stage_pkg::CSR_ALU), "fill");
    end
    issue(build_req(mem_stage_pkg::MEM_STORE, mem_stage_pkg::WIDTH_WORD, 1'b0, 32'h44,
                    next_rand(), mem_stage_pkg::WB_ALU, mem_stage_pkg::CSR_ALU), "word store");
    issue(build_req(mem_stage_pkg::MEM_LOAD, mem_stage_pkg::WIDTH_WORD, 1'b0, 32'h44,
                    32'h0, mem_stage_pkg::WB_LOAD, mem_stage_pkg::CSR_ALU), "word load");
    run_lane_test(32'h140);
    run_extend_test(32'h2c8);
    run_select_test(32'h310);
    run_random_test(N_RANDOM);
    if (n_checked == n_issued && exp_q.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("%0d requests issued but %0d results seen", n_issued, n_checked);
      $display("Something failed");
      $fatal(1);
    end
  end

endmodule

//--- verilog.f
+incdir+include
logic/mem_stage_pkg.sv
logic/writeback_select.sv
logic/lsu.sv
logic/data_sram_axi.sv
logic/mem_stage_top.sv
verif/mem_stage_props.sv
verif/mem_stage_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the mem_stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module mem_stage_tb -Mdir obj_dir

./obj_dir/Vmem_stage_tb
